/* include/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// address split, tag on top, then set index, then byte offset
`define CACHE_TAG_BITS 6
`define CACHE_SET_BITS 6
`define CACHE_OFFSET_BITS 4

// data word width and words per cache block
`define CACHE_WORD_BITS 16
`define CACHE_BLOCK_WORDS 8

// cycles main memory counts before it performs an access
`define CACHE_MEM_LATENCY 4

`endif

/* verilog/cachePkg.sv */
`include "cache_config.svh"

package cachePkg;

   // field view of a byte address
   typedef struct packed {
      logic [`CACHE_TAG_BITS-1:0] tag;
      logic [`CACHE_SET_BITS-1:0] set;
      logic [`CACHE_OFFSET_BITS-1:0] offset;
   } cacheFieldsT;

   // the same address word, seen raw by the memory and split by the cache
   typedef union packed {
      logic [`CACHE_TAG_BITS+`CACHE_SET_BITS+`CACHE_OFFSET_BITS-1:0] raw;
      cacheFieldsT fields;
   } cacheAddrT;

   // one metadata entry, kept per way and per set
   typedef struct packed {
      logic valid;
      logic [`CACHE_TAG_BITS-1:0] tag;
   } cacheMetaT;

   // processor request, held stable by the processor while stall is high
   typedef struct packed {
      logic rd;
      logic wr;
      cacheAddrT addr;
      logic [`CACHE_WORD_BITS-1:0] wdata;
   } cpuReqT;

   // miss controller states
   typedef enum logic [1:0] {
      stateIdle,
      stateFill,
      stateWrite,
      stateDone
   } fillStateT;

endpackage

/* verilog/metaDataArray.sv */
`include "cache_config.svh"

module metaDataArray (
   input  logic clk,
   input  logic arstN,
   input  logic [`CACHE_SET_BITS-1:0] set,
   input  logic wrWay,
   input  logic wrEn,
   input  cachePkg::cacheMetaT wrMeta,
   input  logic lruWrEn,
   input  logic lruIn,
   output cachePkg::cacheMetaT meta0,
   output cachePkg::cacheMetaT meta1,
   output logic lru
);

   localparam int numSets = 1 << `CACHE_SET_BITS;

   // valid and LRU bits are control state and get cleared on reset
   logic [1:0][numSets-1:0] validQ;
   logic [numSets-1:0] lruQ;

   // tags are only meaningful once the matching valid bit is set
   logic [`CACHE_TAG_BITS-1:0] tagQ [2][numSets];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         validQ <= '0;
         lruQ <= '0;
      end else begin
         if (wrEn) begin
            validQ[wrWay][set] <= wrMeta.valid;
         end
         // LRU has its own enable so a read hit leaves the tags alone
         if (lruWrEn) begin
            lruQ[set] <= lruIn;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wrEn) begin
         tagQ[wrWay][set] <= wrMeta.tag;
      end
   end

   // both ways of the addressed set are read out at once for the compare
   assign meta0.valid = validQ[0][set];
   assign meta0.tag = tagQ[0][set];
   assign meta1.valid = validQ[1][set];
   assign meta1.tag = tagQ[1][set];
   assign lru = lruQ[set];

   // a fill must not bring in a tag that the other way of the set already holds
   // two valid copies of one tag would make both ways hit on the next access
   assert property (@(posedge clk) disable iff (!arstN)
      wrEn |-> !(wrWay ? (meta0.valid && (meta0.tag == wrMeta.tag))
                       : (meta1.valid && (meta1.tag == wrMeta.tag))));

endmodule

/* verilog/dataArray.sv */
`include "cache_config.svh"

module dataArray (
   input  logic clk,
   input  logic [`CACHE_SET_BITS:0] blockIndex,
   input  logic [$clog2(`CACHE_BLOCK_WORDS)-1:0] wordIndex,
   input  logic wrEn,
   input  logic [`CACHE_WORD_BITS-1:0] wrData,
   output logic [`CACHE_WORD_BITS-1:0] rdData
);

   // two blocks per set, the way is the low bit of the block index
   localparam int numBlocks = 2 << `CACHE_SET_BITS;

   logic [`CACHE_WORD_BITS-1:0] mem [numBlocks][`CACHE_BLOCK_WORDS];

   // one word per cycle, either a fill word or a write-hit update
   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[blockIndex][wordIndex] <= wrData;
      end
   end

   // read is combinational so a hit returns data in the request cycle
   assign rdData = mem[blockIndex][wordIndex];

endmodule

/* verilog/cacheArray.sv */
`include "cache_config.svh"

module cacheArray (
   input  logic clk,
   input  logic arstN,
   input  cachePkg::cpuReqT req,
   input  logic fillWr,
   input  logic [$clog2(`CACHE_BLOCK_WORDS)-1:0] fillWord,
   input  logic [`CACHE_WORD_BITS-1:0] fillData,
   input  logic fillDone,
   input  logic wrBusy,
   output logic [`CACHE_WORD_BITS-1:0] rdata,
   output logic hit,
   output logic victimWay
);

   import cachePkg::*;

   localparam int wordBits = $clog2(`CACHE_BLOCK_WORDS);

   cacheMetaT meta0;
   cacheMetaT meta1;
   cacheMetaT wrMeta;
   logic lru;
   logic hit0;
   logic hit1;
   logic way;
   logic lruWrEn;
   logic lruIn;
   logic dataWrEn;
   logic [wordBits-1:0] wordIndex;
   logic [`CACHE_WORD_BITS-1:0] wrData;

   // a way hits when it holds a valid copy of the requested tag
   assign hit0 = meta0.valid & (meta0.tag == req.addr.fields.tag);
   assign hit1 = meta1.valid & (meta1.tag == req.addr.fields.tag);
   assign hit = hit0 | hit1;

   // LRU names the way to throw out on the next miss
   assign victimWay = lru;

   // the matching way on a hit, the victim way on a miss and during the fill
   assign way = hit ? hit1 : lru;

   // new tag always goes in valid
   assign wrMeta.valid = 1'b1;
   assign wrMeta.tag = req.addr.fields.tag;

   // a read hit and the end of a fill both point LRU at the other way
   assign lruWrEn = fillDone | (req.rd & hit);
   assign lruIn = ~way;

   metaDataArray metaDataArray_inst (
      .clk(clk),
      .arstN(arstN),
      .set(req.addr.fields.set),
      .wrWay(way),
      .wrEn(fillDone),
      .wrMeta(wrMeta),
      .lruWrEn(lruWrEn),
      .lruIn(lruIn),
      .meta0(meta0),
      .meta1(meta1),
      .lru(lru)
   );

   // fill words take priority, otherwise the processor word is addressed
   assign wordIndex = fillWr ? fillWord : req.addr.fields.offset[`CACHE_OFFSET_BITS-1:1];
   assign wrData = fillWr ? fillData : req.wdata;

   // write-through, so a write hit only updates the cached copy once
   // and a write miss leaves the cache untouched
   assign dataWrEn = fillWr | (req.wr & hit & ~wrBusy);

   dataArray dataArray_inst (
      .clk(clk),
      .blockIndex({req.addr.fields.set, way}),
      .wordIndex(wordIndex),
      .wrEn(dataWrEn),
      .wrData(wrData),
      .rdData(rdata)
   );

   // a fill only ever goes to a set where the tag missed in both ways
   assert property (@(posedge clk) disable iff (!arstN) !(hit0 && hit1));

endmodule

/* verilog/missController.sv */
`include "cache_config.svh"

module missController (
   input  logic clk,
   input  logic arstN,
   input  cachePkg::cpuReqT req,
   input  logic hit,
   input  logic victimWay,
   input  logic memDone,
   input  logic [`CACHE_WORD_BITS-1:0] memRdata,
   output cachePkg::cacheAddrT memAddr,
   output logic memRd,
   output logic memWr,
   output logic [`CACHE_WORD_BITS-1:0] memWdata,
   output logic fillWr,
   output logic [$clog2(`CACHE_BLOCK_WORDS)-1:0] fillWord,
   output logic [`CACHE_WORD_BITS-1:0] fillData,
   output logic fillDone,
   output logic wrBusy,
   output logic stall
);

   import cachePkg::*;

   localparam int wordBits = $clog2(`CACHE_BLOCK_WORDS);

   fillStateT state;
   fillStateT stateNext;
   logic [wordBits-1:0] wordCnt;
   logic [wordBits-1:0] reqWord;
   logic readMiss;
   logic writeReq;
   logic lastWord;

   assign readMiss = req.rd & ~hit;
   assign writeReq = req.wr & ~readMiss;

   // wordCnt is the block word whose read is outstanding
   assign lastWord = (wordCnt == wordBits'(`CACHE_BLOCK_WORDS - 1));

   always_comb begin
      stateNext = state;
      unique case (state)
         stateIdle: begin
            if (readMiss) begin
               stateNext = stateFill;
            end else if (writeReq) begin
               stateNext = stateWrite;
            end
         end
         stateFill: begin
            if (memDone && lastWord) begin
               stateNext = stateDone;
            end
         end
         stateWrite: begin
            if (memDone) begin
               stateNext = stateDone;
            end
         end
         // one cycle for the held request to retire before new work
         stateDone: stateNext = stateIdle;
         default: stateNext = stateIdle;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state <= stateIdle;
         wordCnt <= '0;
      end else begin
         state <= stateNext;
         if (state == stateIdle) begin
            wordCnt <= '0;
         end else if (fillWr) begin
            wordCnt <= wordCnt + 1'b1;
         end
      end
   end

   // first word read goes out in the request cycle itself, later ones
   // go out in the cycle the previous word comes back
   assign memRd = ((state == stateIdle) & readMiss) |
                  ((state == stateFill) & memDone & ~lastWord);
   assign memWr = (state == stateIdle) & writeReq;
   assign memWdata = req.wdata;

   // word address within the block, next word once the current one is back
   assign reqWord = (state == stateFill) ? wordCnt + 1'b1 : '0;

   always_comb begin
      memAddr = req.addr;
      // fills walk the block from its base, writes use the full address
      if (!req.wr) begin
         memAddr.fields.offset = {reqWord, 1'b0};
      end
   end

   // every returned fill word is written into the victim way
   assign fillWr = (state == stateFill) & memDone;
   assign fillWord = wordCnt;
   assign fillData = memRdata;
   assign fillDone = fillWr & lastWord;

   // keeps the cache from writing the same hit word again while memory works
   assign wrBusy = (state == stateWrite) | (state == stateDone);

   // held high while a miss or write has work left, released in stateDone
   assign stall = (readMiss | req.wr) & (state != stateDone);

   // the victim must not change under a running fill, or the block would be split
   assert property (@(posedge clk) disable iff (!arstN)
      (state == stateFill) && !fillDone |=> $stable(victimWay));

endmodule

/* verilog/mainMemory.sv */
`include "cache_config.svh"

module mainMemory (
   input  logic clk,
   input  cachePkg::cacheAddrT addr,
   input  logic rd,
   input  logic wr,
   input  logic [`CACHE_WORD_BITS-1:0] wdata,
   output logic done,
   output logic [`CACHE_WORD_BITS-1:0] rdata
);

   localparam int addrBits = `CACHE_TAG_BITS + `CACHE_SET_BITS + `CACHE_OFFSET_BITS;
   localparam int memWords = 1 << (addrBits - 1);
   localparam int cntBits = $clog2(`CACHE_MEM_LATENCY + 1);

   logic [`CACHE_WORD_BITS-1:0] mem [memWords];

   // latched access, taken from the strobe cycle
   logic [addrBits-2:0] addrQ;
   logic wrQ;
   logic [`CACHE_WORD_BITS-1:0] wdataQ;

   // no reset input here, so the sequencer powers up idle
   logic busy = 1'b0;
   logic doneQ = 1'b0;
   logic [cntBits-1:0] cnt = '0;

   always_ff @(posedge clk) begin
      doneQ <= 1'b0;
      if (!busy) begin
         if (rd || wr) begin
            busy <= 1'b1;
            cnt <= cntBits'(`CACHE_MEM_LATENCY - 1);
            // memory is word addressed, byte bit 0 is dropped
            addrQ <= addr.raw[addrBits-1:1];
            wrQ <= wr;
            wdataQ <= wdata;
         end
      end else if (cnt == '0) begin
         // latency used up, do the access and signal it for one cycle
         busy <= 1'b0;
         doneQ <= 1'b1;
         if (wrQ) begin
            mem[addrQ] <= wdataQ;
         end else begin
            rdata <= mem[addrQ];
         end
      end else begin
         cnt <= cnt - 1'b1;
      end
   end

   assign done = doneQ;

   // the controller may only start the next access once done has been seen
   assert property (@(posedge clk) busy |-> !(rd || wr));

endmodule

/* verilog/cacheTop.sv */
`include "cache_config.svh"

module cacheTop (
   input  logic clk,
   input  logic arstN,
   input  cachePkg::cpuReqT req,
   output logic [`CACHE_WORD_BITS-1:0] rdata,
   output logic stall
);

   import cachePkg::*;

   logic hit;
   logic victimWay;
   logic memDone;
   logic memRd;
   logic memWr;
   logic fillWr;
   logic fillDone;
   logic wrBusy;
   logic [$clog2(`CACHE_BLOCK_WORDS)-1:0] fillWord;
   logic [`CACHE_WORD_BITS-1:0] fillData;
   logic [`CACHE_WORD_BITS-1:0] memRdata;
   logic [`CACHE_WORD_BITS-1:0] memWdata;
   cacheAddrT memAddr;

   // tag compare, data and metadata storage
   cacheArray cacheArray_inst (
      .clk(clk),
      .arstN(arstN),
      .req(req),
      .fillWr(fillWr),
      .fillWord(fillWord),
      .fillData(fillData),
      .fillDone(fillDone),
      .wrBusy(wrBusy),
      .rdata(rdata),
      .hit(hit),
      .victimWay(victimWay)
   );

   // sequences block fills and write-through accesses
   missController missController_inst (
      .clk(clk),
      .arstN(arstN),
      .req(req),
      .hit(hit),
      .victimWay(victimWay),
      .memDone(memDone),
      .memRdata(memRdata),
      .memAddr(memAddr),
      .memRd(memRd),
      .memWr(memWr),
      .memWdata(memWdata),
      .fillWr(fillWr),
      .fillWord(fillWord),
      .fillData(fillData),
      .fillDone(fillDone),
      .wrBusy(wrBusy),
      .stall(stall)
   );

   // backing store behind the cache
   mainMemory mainMemory_inst (
      .clk(clk),
      .addr(memAddr),
      .rd(memRd),
      .wr(memWr),
      .wdata(memWdata),
      .done(memDone),
      .rdata(memRdata)
   );

endmodule

/* sim/cacheTb.sv */
`include "cache_config.svh"

module cacheTb;

   timeunit 1ns;
   timeprecision 1ps;

   import cachePkg::*;

   localparam int wordBits = $clog2(`CACHE_BLOCK_WORDS);
   localparam int numSets = 1 << `CACHE_SET_BITS;
   localparam int resetCycles = 16;
   // a fill is one memory access per block word, plus the cycle that writes the tag
   localparam int missStall = `CACHE_BLOCK_WORDS * (`CACHE_MEM_LATENCY + 1) + 1;
   // a write-through waits for one access and the cycle that sees done
   localparam int writeStall = `CACHE_MEM_LATENCY + 2;
   // worst single request plus the retire cycle and one spare
   localparam int reqBudget = missStall + 2;
   localparam int numRandom = 400;

   // one completed request, used for both the prediction and the observation
   typedef struct packed {
      cacheAddrT addr;
      logic isRead;
      logic hit;
      logic known;
      logic [`CACHE_WORD_BITS-1:0] data;
      logic [7:0] stallCycles;
   } resultT;

   logic clk = 1'b0;
   logic arstN;
   cpuReqT req;
   logic [`CACHE_WORD_BITS-1:0] rdata;
   logic stall;

   string testName;
   int issued = 0;
   int dataErrors = 0;
   int hitErrors = 0;
   int timingErrors = 0;

   resultT expQ [$];
   resultT obsQ [$];
   event resultReady;

   // shadow memory keyed by word address, only words that were written exist
   logic [`CACHE_WORD_BITS-1:0] shadow [int];
   // tag, valid and LRU model per set, LRU names the next victim way
   bit [`CACHE_TAG_BITS-1:0] tagM [numSets][2];
   bit validM [numSets][2];
   bit lruM [numSets];

   // 8 ns clock
   always #4 clk = ~clk;

   cacheTop cacheTop_inst (
      .clk(clk),
      .arstN(arstN),
      .req(req),
      .rdata(rdata),
      .stall(stall)
   );

   function automatic cacheAddrT makeAddr(input int tag, input int set, input int word);
      cacheAddrT a;
      a.fields.tag = `CACHE_TAG_BITS'(tag);
      a.fields.set = `CACHE_SET_BITS'(set);
      // byte offset of the word, bit 0 stays clear
      a.fields.offset = {wordBits'(word), 1'b0};
      return a;
   endfunction

   // way that holds the tag in the model, or -1 when neither does
   function automatic int findWay(input cacheAddrT a);
      int s;
      s = int'(a.fields.set);
      if (validM[s][0] && tagM[s][0] == a.fields.tag) begin
         return 0;
      end
      if (validM[s][1] && tagM[s][1] == a.fields.tag) begin
         return 1;
      end
      return -1;
   endfunction

   // expected result of a request, judged from the model before it is applied
   function automatic resultT predict(input cpuReqT r);
      resultT e;
      int wordAddr;
      e = '0;
      wordAddr = int'(r.addr.raw >> 1);
      e.addr = r.addr;
      e.isRead = r.rd;
      if (r.rd) begin
         e.hit = (findWay(r.addr) >= 0);
         e.known = (shadow.exists(wordAddr) != 0);
         if (e.known) begin
            e.data = shadow[wordAddr];
         end
         e.stallCycles = e.hit ? 8'(0) : 8'(missStall);
      end else begin
         e.stallCycles = 8'(writeStall);
      end
      return e;
   endfunction

   task automatic updateModel(input cpuReqT r);
      int s;
      int w;
      bit v;
      s = int'(r.addr.fields.set);
      w = findWay(r.addr);
      if (r.wr) begin
         // write-through without allocate leaves tags and LRU alone
         shadow[int'(r.addr.raw >> 1)] = r.wdata;
      end else if (w >= 0) begin
         lruM[s] = (w == 0);
      end else begin
         v = lruM[s];
         tagM[s][v] = r.addr.fields.tag;
         validM[s][v] = 1'b1;
         lruM[s] = ~v;
      end
   endtask

   // drives one request and holds it until stall is low
   task automatic issue(input cpuReqT r);
      resultT e;
      resultT o;
      int stallCycles;
      e = predict(r);
      o = '0;
      @(negedge clk);
      req = r;
      issued++;
      stallCycles = 0;
      #1;
      while (stall) begin
         stallCycles++;
         @(negedge clk);
         #1;
      end
      o.addr = r.addr;
      o.isRead = r.rd;
      // a request the cache serves directly never raises stall
      o.hit = (stallCycles == 0);
      o.data = rdata;
      o.stallCycles = 8'(stallCycles);
      updateModel(r);
      expQ.push_back(e);
      obsQ.push_back(o);
      -> resultReady;
   endtask

   task automatic readWord(input int tag, input int set, input int word);
      cpuReqT r;
      r = '0;
      r.rd = 1'b1;
      r.addr = makeAddr(tag, set, word);
      issue(r);
   endtask

   task automatic writeWord(input int tag, input int set, input int word,
                            input logic [`CACHE_WORD_BITS-1:0] data);
      cpuReqT r;
      r = '0;
      r.wr = 1'b1;
      r.addr = makeAddr(tag, set, word);
      r.wdata = data;
      issue(r);
   endtask

   task automatic checkWord(input cacheAddrT addr, input logic [`CACHE_WORD_BITS-1:0] expected,
                            input logic [`CACHE_WORD_BITS-1:0] actual);
      if (actual !== expected) begin
         dataErrors++;
         $display("FAIL %s addr %h: expected data %h, actual %h",
                  testName, addr.raw, expected, actual);
      end
   endtask

   task automatic checkHit(input cacheAddrT addr, input logic expected, input logic actual);
      if (actual !== expected) begin
         hitErrors++;
         $display("FAIL %s addr %h: expected hit %b, actual %b",
                  testName, addr.raw, expected, actual);
      end
   endtask

   task automatic checkCycles(input cacheAddrT addr, input int expected, input int actual);
      if (actual != expected) begin
         timingErrors++;
         $display("FAIL %s addr %h: expected %0d stall cycles, actual %0d",
                  testName, addr.raw, expected, actual);
      end
   endtask

   // compares every completed request against its prediction
   initial begin
      resultT e;
      resultT o;
      forever begin
         @(resultReady);
         while (expQ.size() > 0) begin
            e = expQ.pop_front();
            o = obsQ.pop_front();
            if (e.isRead) begin
               checkHit(e.addr, e.hit, o.hit);
               // words never written have no defined value in memory
               if (e.known) begin
                  checkWord(e.addr, e.data, o.data);
               end
            end
            checkCycles(e.addr, int'(e.stallCycles), int'(o.stallCycles));
         end
      end
   end

   // the budget grows with every request issued, so a stuck request runs out of it
   initial begin
      int cycleCount;
      fillStateT state;
      cycleCount = 0;
      while (cycleCount <= resetCycles + (issued + 1) * reqBudget) begin
         @(posedge clk);
         cycleCount++;
      end
      state = cacheTop_inst.missController_inst.state;
      $display("watchdog expired: request %0d never completed, stall is %b, miss FSM in %s",
               issued, stall, state.name());
      $display("Test FAILED");
      $finish;
   end

   initial begin
      int seedSink;
      int tag;
      int set;
      int word;
      seedSink = $urandom(59);
      req = '0;
      arstN = 1'b0;
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;

      // the write misses and does not allocate, so the read has to fill
      testName = "write then read miss";
      writeWord(5, 3, 2, 16'hA5C3);
      readWord(5, 3, 2);
      testName = "second read hits";
      readWord(5, 3, 2);

      testName = "block word reads";
      for (word = 0; word < `CACHE_BLOCK_WORDS; word++) begin
         writeWord(7, 10, word, `CACHE_WORD_BITS'($urandom));
      end
      // first read brings the block in, every word after that hits
      readWord(7, 10, 0);
      for (word = 0; word < `CACHE_BLOCK_WORDS; word++) begin
         readWord(7, 10, word);
      end

      testName = "lru eviction";
      writeWord(1, 20, 0, 16'h1111);
      writeWord(2, 20, 0, 16'h2222);
      writeWord(3, 20, 0, 16'h3333);
      readWord(1, 20, 0);
      readWord(2, 20, 0);
      // touching tag 1 again leaves tag 2 as least recently used
      readWord(1, 20, 0);
      readWord(3, 20, 0);
      readWord(1, 20, 0);
      readWord(2, 20, 0);

      testName = "write hit";
      writeWord(9, 30, 4, 16'h1234);
      readWord(9, 30, 4);
      writeWord(9, 30, 4, 16'hBEEF);
      readWord(9, 30, 4);
      testName = "write miss no allocate";
      writeWord(11, 31, 4, 16'h0F0F);
      readWord(11, 31, 4);

      // four tags over three sets keep both ways busy and force evictions
      testName = "random mix";
      repeat (numRandom) begin
         tag = int'($urandom_range(3, 0));
         set = 40 + int'($urandom_range(2, 0));
         word = int'($urandom_range(`CACHE_BLOCK_WORDS - 1, 0));
         if ($urandom_range(1, 0) == 1) begin
            writeWord(tag, set, word, `CACHE_WORD_BITS'($urandom));
         end else begin
            readWord(tag, set, word);
         end
      end

      @(negedge clk);
      req = '0;
      repeat (2) @(negedge clk);
      $display("errors: data %0d, hit %0d, timing %0d", dataErrors, hitErrors, timingErrors);
      if (dataErrors + hitErrors + timingErrors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* build.f */
// include path for the shared config header
+incdir+include
// package first, then the RTL bottom up, then the testbench
verilog/cachePkg.sv
verilog/metaDataArray.sv
verilog/dataArray.sv
verilog/cacheArray.sv
verilog/missController.sv
verilog/mainMemory.sv
verilog/cacheTop.sv
sim/cacheTb.sv

/* run.sh */
#!/bin/sh
# builds the cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f build.f --top-module cacheTb \
   --Mdir obj_dir -o cacheSim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/cacheSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Test OK" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
